// File: rvCore.f
rvPkg.sv
mainDecoder.sv
aluDecoder.sv
controlUnit.sv
regFile.sv
immExtend.sv
alu.sv
rvCore.sv
rvCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the testbench prints the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing -f rvCore.f --top-module rvCoreTb -o rvCoreSim \
    && ./obj_dir/rvCoreSim | tee /dev/stderr | grep -qx "test passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

    localparam int opImm       = 'h13;
    localparam int opLoad      = 'h03;
    localparam int opJalr      = 'h67;
    localparam int resetCycles = 16;
    localparam logic [31:0] resetPc = 32'h0;

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] memReadData;
    logic [31:0] pc;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic        memWrite;

    // One entry per executed cycle
    int          grpQ[$];
    logic [31:0] pcQ[$];
    logic [31:0] instrQ[$];
    logic [31:0] readQ[$];
    int          kindQ[$]; // 0 plain, 1 load, 2 store
    logic [31:0] addrQ[$];
    logic [31:0] dataQ[$];

    int passCount = 0;
    int errCount  = 0;
    int cycles    = 0;

    rvCore #(.resetPc(resetPc)) i_dut (
        .clk          (clk),
        .rstN         (rstN),
        .instr        (instr),
        .memReadData  (memReadData),
        .pc           (pc),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > resetCycles + pcQ.size() + 20) begin
            $display("Timeout: the program did not finish after %0d cycles", cycles - 1);
            $display("test failed");
            $finish;
        end
    end

    // RV32I instruction formats
    function automatic logic [31:0] rType(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] sType(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jType(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic string groupName(int grp);
        case (grp)
            1:       return "reset and sequencing";
            2:       return "arithmetic and logic";
            3:       return "loads";
            4:       return "branches";
            default: return "jumps";
        endcase
    endfunction

    task automatic pushRow(int grp, logic [31:0] pcExp, logic [31:0] ins,
                           logic [31:0] rdata, int kind, logic [31:0] addr,
                           logic [31:0] wd);
        grpQ.push_back(grp);
        pcQ.push_back(pcExp);
        instrQ.push_back(ins);
        readQ.push_back(rdata);
        kindQ.push_back(kind);
        addrQ.push_back(addr);
        dataQ.push_back(wd);
    endtask

    task automatic plainRow(int grp, logic [31:0] pcExp, logic [31:0] ins);
        pushRow(grp, pcExp, ins, 0, 0, 0, 0);
    endtask

    task automatic loadRow(int grp, logic [31:0] pcExp, logic [31:0] ins,
                           logic [31:0] rdata, logic [31:0] addr);
        pushRow(grp, pcExp, ins, rdata, 1, addr, 0);
    endtask

    task automatic storeRow(int grp, logic [31:0] pcExp, logic [31:0] ins,
                            logic [31:0] addr, logic [31:0] wd);
        pushRow(grp, pcExp, ins, 0, 2, addr, wd);
    endtask

    task automatic compareValue(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end else begin
            passCount++;
        end
    endtask

    task automatic buildTable();
        plainRow(1, 'h00, iType(5, 0, 0, 1, opImm));       // x1 = 5
        plainRow(1, 'h04, iType(-3, 0, 0, 2, opImm));      // x2 = -3
        storeRow(1, 'h08, sType(0, 1, 0), 'h00, 5);
        plainRow(2, 'h0C, rType(0, 2, 1, 0, 3));           // add
        storeRow(2, 'h10, sType(4, 3, 0), 'h04, 2);
        plainRow(2, 'h14, rType('h20, 2, 1, 0, 4));        // sub
        storeRow(2, 'h18, sType(8, 4, 0), 'h08, 8);
        plainRow(2, 'h1C, rType(0, 1, 2, 2, 5));           // slt -3 < 5
        plainRow(2, 'h20, rType(0, 1, 2, 3, 6));           // sltu sees -3 as huge
        storeRow(2, 'h24, sType(12, 5, 0), 'h0C, 1);
        storeRow(2, 'h28, sType(16, 6, 0), 'h10, 0);
        plainRow(2, 'h2C, rType('h20, 1, 2, 5, 7));        // sra by 5
        plainRow(2, 'h30, rType(0, 1, 2, 5, 8));           // srl by 5
        storeRow(2, 'h34, sType(20, 7, 0), 'h14, 32'hFFFFFFFF);
        storeRow(2, 'h38, sType(24, 8, 0), 'h18, 32'h07FFFFFF);
        plainRow(2, 'h3C, iType('hF0, 2, 4, 9, opImm));    // xori
        plainRow(2, 'h40, iType(4, 1, 1, 10, opImm));      // slli
        plainRow(2, 'h44, iType('h401, 2, 5, 11, opImm));  // srai by 1
        storeRow(2, 'h48, sType(28, 9, 0), 'h1C, 32'hFFFFFF0D);
        storeRow(2, 'h4C, sType(32, 10, 0), 'h20, 'h50);
        storeRow(2, 'h50, sType(36, 11, 0), 'h24, 32'hFFFFFFFE);
        plainRow(2, 'h54, iType('hFF, 2, 7, 18, opImm));   // andi
        plainRow(2, 'h58, rType(0, 3, 18, 6, 19));         // or
        storeRow(2, 'h5C, sType(40, 19, 0), 'h28, 'hFF);
        plainRow(2, 'h60, iType(7, 1, 0, 0, opImm));       // x0 stays zero
        storeRow(2, 'h64, sType(44, 0, 0), 'h2C, 0);
        loadRow(3, 'h68, iType(8, 1, 2, 12, opLoad), 32'h12345678, 'h0D);
        loadRow(3, 'h6C, iType(-4, 1, 2, 13, opLoad), 32'hCAFEF00D, 'h01);
        storeRow(3, 'h70, sType(48, 12, 0), 'h30, 32'h12345678);
        storeRow(3, 'h74, sType(-8, 13, 1), 32'hFFFFFFFD, 32'hCAFEF00D);
        // x1 = 5, x2 = -3; taken branches skip one word
        plainRow(4, 'h78, bType(8, 1, 1, 0));
        plainRow(4, 'h80, bType(8, 2, 1, 0));
        plainRow(4, 'h84, bType(8, 2, 1, 1));
        plainRow(4, 'h8C, bType(8, 1, 1, 1));
        plainRow(4, 'h90, bType(8, 1, 2, 4));
        plainRow(4, 'h98, bType(8, 2, 1, 4));
        plainRow(4, 'h9C, bType(8, 2, 1, 5));
        plainRow(4, 'hA4, bType(8, 1, 2, 5));
        plainRow(4, 'hA8, bType(8, 2, 1, 6));
        plainRow(4, 'hB0, bType(8, 1, 2, 6));
        plainRow(4, 'hB4, bType(8, 1, 2, 7));
        plainRow(4, 'hBC, bType(8, 2, 1, 7));
        plainRow(5, 'hC0, jType('h100, 14));               // x14 = C4
        storeRow(5, 'h1C0, sType(52, 14, 0), 'h34, 'hC4);
        plainRow(5, 'h1C4, iType('h301, 0, 0, 15, opImm));
        plainRow(5, 'h1C8, iType('h10, 15, 0, 16, opJalr)); // 0x311 -> 0x310
        storeRow(5, 'h310, sType(56, 16, 0), 'h38, 'h1CC);
        plainRow(5, 'h314, jType(-'h200, 17));             // backward jal
        plainRow(5, 'h114, bType(-16, 0, 0, 0));           // backward beq
        storeRow(5, 'h104, sType(60, 17, 0), 'h3C, 'h318);
        plainRow(5, 'h108, iType(-4, 15, 0, 0, opJalr));
        storeRow(5, 'h2FC, sType(64, 15, 0), 'h40, 'h301);
    endtask

    initial begin
        int  groupErr;
        logic lastInGroup;
        clk         = 1'b0;
        rstN        = 1'b0;
        instr       = sType(0, 1, 0); // A store that reset must hold off
        memReadData = '0;
        groupErr    = 0;
        buildTable();
        for (int k = 0; k < resetCycles; k++) begin
            @(negedge clk);
            compareValue("memWrite in reset", {31'b0, memWrite}, 32'd0);
            compareValue("pc in reset", pc, resetPc);
        end
        for (int i = 0; i < pcQ.size(); i++) begin
            if (i > 0)
                @(negedge clk);
            rstN        = 1'b1;
            instr       = instrQ[i];
            memReadData = readQ[i];
            #1;
            compareValue("pc", pc, pcQ[i]);
            compareValue("memWrite", {31'b0, memWrite}, (kindQ[i] == 2) ? 32'd1 : 32'd0);
            if (kindQ[i] != 0)
                compareValue("memAddr", memAddr, addrQ[i]);
            if (kindQ[i] == 2)
                compareValue("memWriteData", memWriteData, dataQ[i]);
            if (i == pcQ.size() - 1)
                lastInGroup = 1'b1;
            else
                lastInGroup = (grpQ[i + 1] != grpQ[i]);
            if (lastInGroup) begin
                $display("Test %0d, %s: %0d errors", grpQ[i], groupName(grpQ[i]),
                         errCount - groupErr);
                groupErr = errCount;
            end
        end
        $display("Checks passed %0d, errors %0d", passCount, errCount);
        if (errCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
    parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [rvPkg::xlen-1:0] instr,
    input  logic [rvPkg::xlen-1:0] memReadData,
    output logic [rvPkg::xlen-1:0] pc,
    output logic [rvPkg::xlen-1:0] memAddr,
    output logic [rvPkg::xlen-1:0] memWriteData,
    output logic                   memWrite
);

    logic                   regWrite;
    logic                   aluSrc;
    logic                   storeEn;
    rvPkg::aluOpT           aluOp;
    rvPkg::immSrcT          immSrc;
    rvPkg::resultSrcT       resultSrc;
    rvPkg::pcSrcT           pcSrc;
    logic                   cmpEq;
    logic                   cmpLt;
    logic                   cmpLtu;
    logic [rvPkg::xlen-1:0] rs1Data;
    logic [rvPkg::xlen-1:0] rs2Data;
    logic [rvPkg::xlen-1:0] imm;
    logic [rvPkg::xlen-1:0] srcB;
    logic [rvPkg::xlen-1:0] aluY;
    logic [rvPkg::xlen-1:0] result;
    logic [rvPkg::xlen-1:0] pcPlus4;
    logic [rvPkg::xlen-1:0] pcTarget;
    logic [rvPkg::xlen-1:0] pcNext;

    controlUnit i_controlUnit (
        .instr     (instr),
        .cmpEq     (cmpEq),
        .cmpLt     (cmpLt),
        .cmpLtu    (cmpLtu),
        .regWrite  (regWrite),
        .aluSrc    (aluSrc),
        .memWrite  (storeEn),
        .aluOp     (aluOp),
        .immSrc    (immSrc),
        .resultSrc (resultSrc),
        .pcSrc     (pcSrc)
    );

    regFile i_regFile (
        .clk  (clk),
        .rstN (rstN),
        .we   (regWrite),
        .ra1  (instr[19:15]),
        .ra2  (instr[24:20]),
        .wa   (instr[11:7]),
        .wd   (result),
        .rd1  (rs1Data),
        .rd2  (rs2Data)
    );

    immExtend i_immExtend (
        .instr  (instr),
        .immSrc (immSrc),
        .imm    (imm)
    );

    assign srcB = aluSrc ? imm : rs2Data;

    alu i_alu (
        .a      (rs1Data),
        .b      (srcB),
        .aluOp  (aluOp),
        .y      (aluY),
        .cmpEq  (cmpEq),
        .cmpLt  (cmpLt),
        .cmpLtu (cmpLtu)
    );

    always_comb begin
        case (resultSrc)
            rvPkg::resMem:     result = memReadData;
            rvPkg::resPcPlus4: result = pcPlus4; // link value
            default:           result = aluY;
        endcase
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;

    always_comb begin
        case (pcSrc)
            rvPkg::pcTarget: pcNext = pcTarget;
            rvPkg::pcJalr:   pcNext = {aluY[rvPkg::xlen-1:1], 1'b0};
            default:         pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            pc <= resetPc;
        else
            pc <= pcNext;
    end

    // No stores while held in reset
    assign memWrite     = storeEn & rstN;
    assign memAddr      = aluY;
    assign memWriteData = rs2Data;

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    input  rvPkg::aluOpT           aluOp,
    output logic [rvPkg::xlen-1:0] y,
    output logic                   cmpEq,
    output logic                   cmpLt,
    output logic                   cmpLtu
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // Flags compare a and b regardless of aluOp
    assign cmpEq  = (a == b);
    assign cmpLt  = ($signed(a) < $signed(b));
    assign cmpLtu = (a < b);

    always_comb begin
        case (aluOp)
            rvPkg::aluSub:  y = a - b;
            rvPkg::aluAnd:  y = a & b;
            rvPkg::aluOr:   y = a | b;
            rvPkg::aluXor:  y = a ^ b;
            rvPkg::aluSlt:  y = {{(rvPkg::xlen-1){1'b0}}, cmpLt};
            rvPkg::aluSltu: y = {{(rvPkg::xlen-1){1'b0}}, cmpLtu};
            rvPkg::aluSll:  y = a << shamt;
            rvPkg::aluSrl:  y = a >> shamt;
            rvPkg::aluSra:  y = $unsigned($signed(a) >>> shamt);
            default:        y = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: immExtend.sv
`timescale 1ns/1ps
`default_nettype none

module immExtend (
    input  logic [rvPkg::xlen-1:0] instr,
    input  rvPkg::immSrcT          immSrc,
    output logic [rvPkg::xlen-1:0] imm
);

    localparam int xlen = rvPkg::xlen;

    always_comb begin
        case (immSrc)
            rvPkg::immS:
                imm = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::immB:
                imm = {{(xlen-12){instr[31]}}, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            rvPkg::immJ:
                imm = {{(xlen-20){instr[31]}}, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default: // I format
                imm = {{(xlen-12){instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   we,
    input  logic [4:0]             ra1,
    input  logic [4:0]             ra2,
    input  logic [4:0]             wa,
    input  logic [rvPkg::xlen-1:0] wd,
    output logic [rvPkg::xlen-1:0] rd1,
    output logic [rvPkg::xlen-1:0] rd2
);

    logic [rvPkg::xlen-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic [rvPkg::xlen-1:0] instr,
    input  logic                   cmpEq,
    input  logic                   cmpLt,
    input  logic                   cmpLtu,
    output logic                   regWrite,
    output logic                   aluSrc,
    output logic                   memWrite,
    output rvPkg::aluOpT           aluOp,
    output rvPkg::immSrcT          immSrc,
    output rvPkg::resultSrcT       resultSrc,
    output rvPkg::pcSrcT           pcSrc
);

    rvPkg::opcodeT   opcode;
    logic [2:0]      funct3;
    logic            funct7b5;
    logic            branch;
    logic            taken;
    rvPkg::aluClassT aluClass;

    assign opcode   = rvPkg::opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    mainDecoder i_mainDecoder (
        .opcode    (opcode),
        .regWrite  (regWrite),
        .aluSrc    (aluSrc),
        .memWrite  (memWrite),
        .branch    (branch),
        .immSrc    (immSrc),
        .resultSrc (resultSrc),
        .aluClass  (aluClass)
    );

    aluDecoder i_aluDecoder (
        .aluClass (aluClass),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .aluOp    (aluOp)
    );

    // Branch condition from funct3
    always_comb begin
        case (funct3)
            3'b000:  taken = cmpEq;   // beq
            3'b001:  taken = !cmpEq;  // bne
            3'b100:  taken = cmpLt;   // blt
            3'b101:  taken = !cmpLt;  // bge
            3'b110:  taken = cmpLtu;  // bltu
            3'b111:  taken = !cmpLtu; // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (opcode == rvPkg::opJal)
            pcSrc = rvPkg::pcTarget;
        else if (opcode == rvPkg::opJalr)
            pcSrc = rvPkg::pcJalr;
        else if (branch && taken)
            pcSrc = rvPkg::pcTarget;
        else
            pcSrc = rvPkg::pcPlus4;
    end

endmodule

`default_nettype wire

// File: aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
    input  rvPkg::aluClassT aluClass,
    input  logic [2:0]      funct3,
    input  logic            funct7b5,
    output rvPkg::aluOpT    aluOp
);

    always_comb begin
        case (aluClass)
            rvPkg::clsAdd:    aluOp = rvPkg::aluAdd;
            rvPkg::clsBranch: aluOp = rvPkg::aluSub;
            default: begin
                case (funct3)
                    // sub only exists in register form
                    3'b000:  aluOp = (aluClass == rvPkg::clsOp && funct7b5)
                                     ? rvPkg::aluSub : rvPkg::aluAdd;
                    3'b001:  aluOp = rvPkg::aluSll;
                    3'b010:  aluOp = rvPkg::aluSlt;
                    3'b011:  aluOp = rvPkg::aluSltu;
                    3'b100:  aluOp = rvPkg::aluXor;
                    3'b101:  aluOp = funct7b5 ? rvPkg::aluSra : rvPkg::aluSrl;
                    3'b110:  aluOp = rvPkg::aluOr;
                    default: aluOp = rvPkg::aluAnd;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// File: mainDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
    input  rvPkg::opcodeT    opcode,
    output logic             regWrite,
    output logic             aluSrc,
    output logic             memWrite,
    output logic             branch,
    output rvPkg::immSrcT    immSrc,
    output rvPkg::resultSrcT resultSrc,
    output rvPkg::aluClassT  aluClass
);

    always_comb begin
        // Inactive word unless the opcode is known
        regWrite  = 1'b0;
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        immSrc    = rvPkg::immI;
        resultSrc = rvPkg::resAlu;
        aluClass  = rvPkg::clsAdd;
        case (opcode)
            rvPkg::opOp: begin
                regWrite = 1'b1;
                aluClass = rvPkg::clsOp;
            end
            rvPkg::opOpImm: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluClass = rvPkg::clsOpImm;
            end
            rvPkg::opLoad: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = rvPkg::resMem;
            end
            rvPkg::opStore: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immSrc   = rvPkg::immS;
            end
            rvPkg::opBranch: begin
                branch   = 1'b1;
                immSrc   = rvPkg::immB;
                aluClass = rvPkg::clsBranch;
            end
            rvPkg::opJal: begin
                regWrite  = 1'b1;
                immSrc    = rvPkg::immJ;
                resultSrc = rvPkg::resPcPlus4;
            end
            rvPkg::opJalr: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1; // rs1 + imm is the target
                resultSrc = rvPkg::resPcPlus4;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rvPkg.sv
`default_nettype none

package rvPkg;

    parameter int xlen = 32;

    // Major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opOpImm  = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSlt  = 4'd5,
        aluSltu = 4'd6,
        aluSll  = 4'd7,
        aluSrl  = 4'd8,
        aluSra  = 4'd9
    } aluOpT;

    // Main decoder to ALU decoder
    typedef enum logic [1:0] {
        clsAdd    = 2'd0,
        clsOp     = 2'd1,
        clsOpImm  = 2'd2,
        clsBranch = 2'd3
    } aluClassT;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3
    } immSrcT;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultSrcT;

    typedef enum logic [1:0] {
        pcPlus4  = 2'd0,
        pcTarget = 2'd1, // pc + imm
        pcJalr   = 2'd2  // ALU result with bit 0 cleared
    } pcSrcT;

endpackage

`default_nettype wire
